/* src/uart_defs.svh */
// UART widths, FIFO depth and divider reset value
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`default_nettype none

// Character and register widths
`define UART_DATA_W     8
`define UART_BUS_W      32

// Bit period is DIV+1 clock cycles
`define UART_DIV_W      16
`define UART_DIV_RESET  15

`define UART_FIFO_DEPTH 16

`default_nettype wire

`endif

/* src/uart_pkg.sv */
// UART shared types: register addresses, bus request, control, status, FSM states
`include "uart_defs.svh"

`default_nettype none

package uart_pkg;

    typedef enum logic [2:0] {
        REG_CTRL   = 3'd0,
        REG_DIV    = 3'd1,
        REG_STATUS = 3'd2,
        REG_TXDATA = 3'd3,
        REG_RXDATA = 3'd4,
        REG_PARAM  = 3'd5
    } reg_addr_e;

    typedef struct packed {
        logic                   we;
        reg_addr_e              addr;
        logic [`UART_BUS_W-1:0] wdata;
    } reg_req_t;

    // ~~~~~~~~~~~~~~~~~~~~
    // Register fields
    typedef struct packed {
        logic tx_reset;
        logic rx_reset;
        logic parity_en;
        logic parity_odd;
    } uart_ctrl_t;

    typedef struct packed {
        logic tx_empty;
        logic tx_full;
        logic rx_empty;
        logic rx_full;
    } uart_status_t;

    typedef struct packed {
        logic                    parity_err;
        logic [`UART_DATA_W-1:0] data;
    } rx_word_t; // One rx FIFO entry

    // ~~~~~~~~~~~~~~~~~~~~
    // Serializer and deserializer states
    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;
    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

/* src/uart_fifo.sv */
// Synchronous first-word-fall-through FIFO with valid/ready on both sides
`default_nettype none

module uart_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output logic             full_o,
    output logic             empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;
    logic             push;
    logic             pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) mem[wr_ptr_q] <= in_data_i;
    end

    assign full_o      = (count_q == CW'(DEPTH));
    assign empty_o     = (count_q == '0);
    assign in_ready_o  = !full_o;
    assign out_valid_o = !empty_o;
    assign out_data_o  = mem[rd_ptr_q];   // Fall-through read

endmodule

`default_nettype wire

/* src/uart_tx.sv */
// UART serializer: start bit, data LSB first, optional parity, stop bit
`include "uart_defs.svh"

`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  uart_ctrl_t              ctrl_i,
    input  logic [`UART_DIV_W-1:0]  div_i,
    input  logic [`UART_DATA_W-1:0] data_i,
    input  logic                    valid_i,
    output logic                    ready_o,
    output logic                    tx_o
);

    localparam int BW = $clog2(`UART_DATA_W);

    tx_state_e               state_q;
    logic [`UART_DIV_W-1:0]  div_cnt_q;
    logic [BW-1:0]           bit_cnt_q;
    logic [`UART_DATA_W-1:0] shift_q;
    logic                    par_q;
    logic                    tx_q;
    logic                    bit_tick;

    assign bit_tick = (div_cnt_q >= div_i);   // End of the current bit
    assign ready_o  = (state_q == TX_IDLE);
    assign tx_o     = tx_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= TX_IDLE;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            tx_q      <= 1'b1;   // Line idles high
        end else begin
            div_cnt_q <= (state_q == TX_IDLE || bit_tick) ? '0 : div_cnt_q + 1'b1;
            case (state_q)
                TX_IDLE: begin
                    if (valid_i) begin
                        state_q <= TX_START;
                        tx_q    <= 1'b0;
                    end
                end
                TX_START: begin
                    if (bit_tick) begin
                        state_q   <= TX_DATA;
                        bit_cnt_q <= '0;
                        tx_q      <= shift_q[0];
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        if (bit_cnt_q == BW'(`UART_DATA_W - 1)) begin
                            state_q <= ctrl_i.parity_en ? TX_PARITY : TX_STOP;
                            tx_q    <= ctrl_i.parity_en ? par_q : 1'b1;
                        end else begin
                            bit_cnt_q <= bit_cnt_q + 1'b1;
                            tx_q      <= shift_q[1];
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_tick) begin
                        state_q <= TX_STOP;
                        tx_q    <= 1'b1;
                    end
                end
                TX_STOP: if (bit_tick) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Character and its parity bit
    always_ff @(posedge clk_i) begin
        if (state_q == TX_IDLE && valid_i) begin
            shift_q <= data_i;
            par_q   <= (^data_i) ^ ctrl_i.parity_odd;
        end else if (state_q == TX_DATA && bit_tick) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

`default_nettype wire

/* src/uart_rx.sv */
// UART deserializer: input synchronizer, start detection, mid-bit sampling, parity check
`include "uart_defs.svh"

`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  uart_ctrl_t             ctrl_i,
    input  logic [`UART_DIV_W-1:0] div_i,
    input  logic                   rx_i,
    output rx_word_t               word_o,
    output logic                   valid_o,
    input  logic                   ready_i
);

    localparam int BW = $clog2(`UART_DATA_W);

    rx_state_e               state_q;
    logic [1:0]              sync_q;
    logic [`UART_DIV_W-1:0]  div_cnt_q;
    logic [BW-1:0]           bit_cnt_q;
    logic [`UART_DATA_W-1:0] shift_q;
    logic                    perr_q;
    logic                    valid_q;
    logic                    rx_s;
    logic                    mid_tick;
    logic                    bit_tick;

    assign rx_s     = sync_q[1];
    assign mid_tick = (div_cnt_q >= (div_i >> 1));   // Half a bit after the falling edge
    assign bit_tick = (div_cnt_q >= div_i);          // One full bit, mid to mid

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= RX_IDLE;
            sync_q    <= '1;
            div_cnt_q <= '0;
            bit_cnt_q <= '0;
            valid_q   <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], rx_i};
            valid_q   <= 1'b0;
            div_cnt_q <= div_cnt_q + 1'b1;
            case (state_q)
                RX_IDLE: begin
                    div_cnt_q <= '0;
                    if (!rx_s) state_q <= RX_START;
                end
                RX_START: begin
                    if (mid_tick) begin
                        div_cnt_q <= '0;
                        bit_cnt_q <= '0;
                        state_q   <= rx_s ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        div_cnt_q <= '0;
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BW'(`UART_DATA_W - 1))
                            state_q <= ctrl_i.parity_en ? RX_PARITY : RX_STOP;
                    end
                end
                RX_PARITY: begin
                    if (bit_tick) begin
                        div_cnt_q <= '0;
                        state_q   <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_tick) begin
                        state_q <= RX_IDLE;
                        // Bad stop bit or full FIFO drops the word
                        valid_q <= rx_s && ready_i;
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_START) perr_q <= 1'b0;
        if (state_q == RX_DATA && bit_tick) shift_q <= {rx_s, shift_q[`UART_DATA_W-1:1]};
        if (state_q == RX_PARITY && bit_tick)
            perr_q <= rx_s ^ (^shift_q) ^ ctrl_i.parity_odd;
    end

    assign word_o.parity_err = perr_q;
    assign word_o.data       = shift_q;
    assign valid_o           = valid_q;

endmodule

`default_nettype wire

/* src/uart_reg_file.sv */
// UART register file: four-phase register port, CTRL and DIV registers, FIFO push and pop
`include "uart_defs.svh"

`default_nettype none

module uart_reg_file
    import uart_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    req_i,
    input  reg_req_t                bus_i,
    output logic                    ack_o,
    output logic [`UART_BUS_W-1:0]  rdata_o,
    output uart_ctrl_t              ctrl_o,
    output logic [`UART_DIV_W-1:0]  div_o,
    output logic [`UART_DATA_W-1:0] tx_data_o,
    output logic                    tx_valid_o,
    input  logic                    tx_ready_i,
    input  rx_word_t                rx_word_i,
    input  logic                    rx_valid_i,
    output logic                    rx_ready_o,
    input  uart_status_t            status_i
);

    typedef enum logic [1:0] {S_IDLE, S_DECODE, S_ACCESS, S_ACK} bus_state_e;

    bus_state_e                state_q;
    reg_req_t                  bus_q;
    logic                      tx_push_q;
    logic                      rx_pop_q;
    uart_ctrl_t                ctrl_q;
    logic [`UART_DIV_W-1:0]    div_q;
    logic [`UART_BUS_W-1:0]    rdata_q;
    logic [`UART_BUS_W-1:0]    rd_word;

    // ~~~~~~~~~~~~~~~~~~~~
    // Read mux
    always_comb begin
        rd_word = '0;
        case (bus_q.addr)
            REG_CTRL:   rd_word[$bits(uart_ctrl_t)-1:0]   = ctrl_q;
            REG_DIV:    rd_word[`UART_DIV_W-1:0]          = div_q;
            REG_STATUS: rd_word[$bits(uart_status_t)-1:0] = status_i;
            REG_RXDATA: begin
                if (rx_valid_i) begin                      // Empty FIFO reads as zero
                    rd_word[`UART_BUS_W-1]          = 1'b1;
                    rd_word[$bits(rx_word_t)-1:0]   = rx_word_i;
                end
            end
            REG_PARAM: begin
                rd_word[15:0]  = 16'(`UART_FIFO_DEPTH);
                rd_word[23:16] = 8'(`UART_DATA_W);
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Handshake FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            tx_push_q <= 1'b0;
            rx_pop_q  <= 1'b0;
            ctrl_q    <= '0;
            div_q     <= `UART_DIV_W'(`UART_DIV_RESET);
        end else begin
            case (state_q)
                S_IDLE: if (req_i) state_q <= S_DECODE;
                S_DECODE: begin
                    tx_push_q <= bus_q.we && (bus_q.addr == REG_TXDATA);
                    rx_pop_q  <= !bus_q.we && (bus_q.addr == REG_RXDATA);
                    state_q   <= S_ACCESS;
                end
                S_ACCESS: begin
                    if (!tx_push_q || tx_ready_i) begin    // Hold here while tx FIFO full
                        if (bus_q.we && bus_q.addr == REG_CTRL)
                            ctrl_q <= uart_ctrl_t'(bus_q.wdata[$bits(uart_ctrl_t)-1:0]);
                        if (bus_q.we && bus_q.addr == REG_DIV)
                            div_q <= bus_q.wdata[`UART_DIV_W-1:0];
                        tx_push_q <= 1'b0;
                        rx_pop_q  <= 1'b0;
                        state_q   <= S_ACK;
                    end
                end
                S_ACK: if (!req_i) state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_IDLE && req_i) bus_q <= bus_i;
        if (state_q == S_ACCESS) rdata_q <= rd_word;
    end

    assign tx_valid_o = (state_q == S_ACCESS) && tx_push_q;
    assign rx_ready_o = (state_q == S_ACCESS) && rx_pop_q;  // Single cycle, so one pop
    assign tx_data_o  = bus_q.wdata[`UART_DATA_W-1:0];
    assign ack_o      = (state_q == S_ACK);
    assign rdata_o    = rdata_q;
    assign ctrl_o     = ctrl_q;
    assign div_o      = div_q;

endmodule

`default_nettype wire

/* src/uart_top.sv */
// UART top level: register file, tx and rx FIFOs, serializer and deserializer
`include "uart_defs.svh"

`default_nettype none

module uart_top
    import uart_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   bus_req_i,
    input  reg_req_t               bus_i,
    output logic                   bus_ack_o,
    output logic [`UART_BUS_W-1:0] bus_rdata_o,
    input  logic                   uart_rx_i,
    output logic                   uart_tx_o
);

    uart_ctrl_t              ctrl;
    uart_status_t            status;
    logic [`UART_DIV_W-1:0]  div;
    logic                    tx_rst;
    logic                    rx_rst;

    logic [`UART_DATA_W-1:0] reg_tx_data;   // Register file to tx FIFO
    logic                    reg_tx_valid;
    logic                    reg_tx_ready;
    logic [`UART_DATA_W-1:0] ser_data;      // tx FIFO to serializer
    logic                    ser_valid;
    logic                    ser_ready;
    rx_word_t                des_word;      // Deserializer to rx FIFO
    logic                    des_valid;
    logic                    des_ready;
    rx_word_t                reg_rx_word;   // rx FIFO to register file
    logic                    reg_rx_valid;
    logic                    reg_rx_ready;

    // Software resets per direction
    assign tx_rst = rst_i || ctrl.tx_reset;
    assign rx_rst = rst_i || ctrl.rx_reset;

    uart_reg_file i_uart_reg_file (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (bus_req_i),
        .bus_i     (bus_i),
        .ack_o     (bus_ack_o),
        .rdata_o   (bus_rdata_o),
        .ctrl_o    (ctrl),
        .div_o     (div),
        .tx_data_o (reg_tx_data),
        .tx_valid_o(reg_tx_valid),
        .tx_ready_i(reg_tx_ready),
        .rx_word_i (reg_rx_word),
        .rx_valid_i(reg_rx_valid),
        .rx_ready_o(reg_rx_ready),
        .status_i  (status)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Transmit path
    uart_fifo #(
        .WIDTH(`UART_DATA_W),
        .DEPTH(`UART_FIFO_DEPTH)
    ) i_uart_fifo_tx (
        .clk_i      (clk_i),
        .rst_i      (tx_rst),
        .in_data_i  (reg_tx_data),
        .in_valid_i (reg_tx_valid),
        .in_ready_o (reg_tx_ready),
        .out_data_o (ser_data),
        .out_valid_o(ser_valid),
        .out_ready_i(ser_ready),
        .full_o     (status.tx_full),
        .empty_o    (status.tx_empty)
    );

    uart_tx i_uart_tx (
        .clk_i  (clk_i),
        .rst_i  (tx_rst),
        .ctrl_i (ctrl),
        .div_i  (div),
        .data_i (ser_data),
        .valid_i(ser_valid),
        .ready_o(ser_ready),
        .tx_o   (uart_tx_o)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // Receive path
    uart_rx i_uart_rx (
        .clk_i  (clk_i),
        .rst_i  (rx_rst),
        .ctrl_i (ctrl),
        .div_i  (div),
        .rx_i   (uart_rx_i),
        .word_o (des_word),
        .valid_o(des_valid),
        .ready_i(des_ready)
    );

    uart_fifo #(
        .WIDTH($bits(rx_word_t)),
        .DEPTH(`UART_FIFO_DEPTH)
    ) i_uart_fifo_rx (
        .clk_i      (clk_i),
        .rst_i      (rx_rst),
        .in_data_i  (des_word),
        .in_valid_i (des_valid),
        .in_ready_o (des_ready),
        .out_data_o (reg_rx_word),
        .out_valid_o(reg_rx_valid),
        .out_ready_i(reg_rx_ready),
        .full_o     (status.rx_full),
        .empty_o    (status.rx_empty)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
// Testbench clock generator and power-on reset
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;   // Released on a rising edge
    end

endmodule

`default_nettype wire

/* dv/uart_checker.sv */
// Register port handshake and FIFO transfer assertions, bound into the register file
`default_nettype none

module uart_checker (
    input logic clk_i,
    input logic rst_i,
    input logic req_i,
    input logic ack_i,
    input logic tx_valid_i,
    input logic tx_ready_i,
    input logic rx_ready_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // ~~~~~~~~~~~~~~~~~~~~
    // Four-phase handshake
    a_no_ack_unasked: assert property (@(posedge clk_i) disable iff (rst_i)
        !req_i && !ack_i |=> !ack_i)
        else $error("bus_ack_o rose with no request");

    a_ack_held: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && ack_i |=> ack_i)
        else $error("bus_ack_o dropped while the request was still high");

    a_ack_released: assert property (@(posedge clk_i) disable iff (rst_i)
        ack_i && !req_i |=> !ack_i)
        else $error("bus_ack_o stayed high after the request dropped");

    // ~~~~~~~~~~~~~~~~~~~~
    // FIFO transfers
    a_pop_single: assert property (@(posedge clk_i) disable iff (rst_i)
        rx_ready_i |=> !rx_ready_i)
        else $error("rx FIFO pop lasted more than one cycle");

    a_push_held: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_valid_i && !tx_ready_i |=> tx_valid_i)
        else $error("tx push withdrawn under back-pressure");

    // Idle bus moves no data
    a_quiet_bus: assert property (@(posedge clk_i) disable iff (rst_i)
        !req_i && !ack_i |-> !tx_valid_i && !rx_ready_i)
        else $error("FIFO transfer with the register port idle");

endmodule

`default_nettype wire

/* dv/uart_tb.sv */
// UART testbench: register port driver, frame reference, serial monitor, test sequence
`include "uart_defs.svh"

`default_nettype none

module uart_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIV_FAST = 7;
    localparam int N_RANDOM = 20;
    localparam int N_PARITY = 8;
    localparam int N_BAD    = 3;
    localparam int N_QUIET  = 4;
    // 11 bits per frame, doubled for register traffic
    localparam int TIMEOUT_CYCLES = 11 * 2 * (N_RANDOM * (`UART_DIV_RESET + 1)
        + (2 * N_PARITY + N_BAD + N_QUIET) * (DIV_FAST + 1)) + 4000;

    localparam uart_status_t ST_ALL_EMPTY =
        '{tx_empty: 1'b1, tx_full: 1'b0, rx_empty: 1'b1, rx_full: 1'b0};
    localparam uart_status_t ST_TX_FULL =
        '{tx_empty: 1'b0, tx_full: 1'b1, rx_empty: 1'b1, rx_full: 1'b0};

    logic                   clk;
    logic                   rst;
    logic                   bus_req;
    reg_req_t               bus;
    logic                   bus_ack;
    logic [`UART_BUS_W-1:0] bus_rdata;
    logic                   uart_rx;
    logic                   uart_tx;
    logic                   drv_line;     // Frame driver output
    logic                   loop_sel;     // 1 selects loopback
    logic                   mon_en;
    uart_ctrl_t             cur_ctrl;     // Shadow of CTRL
    int                     cur_div;
    logic [7:0]             frame_q[$];   // Bytes expected on uart_tx_o
    logic [31:0]            lcg_state;
    int                     cycle_cnt;
    int                     n_checks;
    int                     n_errors;
    int                     test_errs;

    tb_clk_gen i_tb_clk_gen (
        .clk_o(clk),
        .rst_o(rst)
    );

    uart_top uart_top_i (
        .clk_i      (clk),
        .rst_i      (rst),
        .bus_req_i  (bus_req),
        .bus_i      (bus),
        .bus_ack_o  (bus_ack),
        .bus_rdata_o(bus_rdata),
        .uart_rx_i  (uart_rx),
        .uart_tx_o  (uart_tx)
    );

    bind uart_reg_file uart_checker i_uart_checker (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .ack_i     (ack_o),
        .tx_valid_i(tx_valid_o),
        .tx_ready_i(tx_ready_i),
        .rx_ready_i(rx_ready_o)
    );

    assign uart_rx = loop_sel ? uart_tx : drv_line;

    // ~~~~~~~~~~~~~~~~~~~~
    // Reference model
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Frame bits in line order with the start bit at bit 0
    function automatic logic [10:0] ref_frame(input logic [7:0] data, input uart_ctrl_t ctrl);
        logic ones_odd;
        logic par;
        ones_odd = ($countones(data) % 2) == 1;
        par = ctrl.parity_odd ? !ones_odd : ones_odd;   // Total count of ones even or odd
        if (ctrl.parity_en)
            return {1'b1, par, data, 1'b0};
        return {2'b11, data, 1'b0};   // Stop bit, then idle
    endfunction

    function automatic int frame_bits(input uart_ctrl_t ctrl);
        return ctrl.parity_en ? 11 : 10;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    task automatic note_error();
        n_errors++;
        test_errs++;
    endtask

    task automatic check_rdata(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: bus_rdata_o (%s) got %h expected %h",
                     $time, name, got, exp);
            note_error();
        end
    endtask

    task automatic check_status(input logic [31:0] got, input uart_status_t exp);
        n_checks++;
        if (got !== {28'd0, exp}) begin
            $display("** Error at %0t ns: bus_rdata_o (STATUS) got %h expected %h",
                     $time, got, {28'd0, exp});
            note_error();
        end
    endtask

    task automatic check_rx_word(input logic [31:0] got, input rx_word_t exp);
        logic [31:0] exp_word;
        exp_word = {1'b1, 22'd0, exp};   // Valid flag on top
        n_checks++;
        if (got !== exp_word) begin
            $display("** Error at %0t ns: bus_rdata_o (RXDATA) got %h expected %h",
                     $time, got, exp_word);
            note_error();
        end
    endtask

    task automatic check_line_bit(input int idx, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            $display("** Error at %0t ns: uart_tx_o bit %0d got %b expected %b",
                     $time, idx, got, exp);
            note_error();
        end
    endtask

    task automatic end_test(input string name);
        $display("[%0t ns] %s: %0d errors", $time, name, test_errs);
        test_errs = 0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // Register port and frame driver
    task automatic bus_access(input logic we, input reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        reg_req_t req;
        req.we    = we;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        bus     <= req;
        bus_req <= 1'b1;
        @(negedge clk);
        while (!bus_ack) @(negedge clk);
        rdata = bus_rdata;
        @(posedge clk);
        bus_req <= 1'b0;
        @(negedge clk);
        while (bus_ack) @(negedge clk);
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, addr, data, unused);
        if (addr == REG_CTRL) cur_ctrl = uart_ctrl_t'(data[3:0]);
        if (addr == REG_DIV) cur_div = int'(data[15:0]);
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [31:0] data);
        bus_access(1'b0, addr, 32'd0, data);
    endtask

    task automatic poll_rx(output logic [31:0] data);
        read_reg(REG_RXDATA, data);
        while (!data[31]) read_reg(REG_RXDATA, data);
    endtask

    task automatic drive_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        bits = ref_frame(data, cur_ctrl);
        if (bad_parity) bits[9] = ~bits[9];
        for (int i = 0; i < frame_bits(cur_ctrl); i++) begin
            @(posedge clk);
            drv_line <= bits[i];
            repeat (cur_div) @(posedge clk);
        end
    endtask

    // Samples uart_tx_o at mid-bit against the reference frame
    initial begin
        logic [10:0] exp_bits;
        int          nbits;
        int          div;
        forever begin
            @(negedge clk);
            if (mon_en && !uart_tx) begin
                if (frame_q.size() == 0) begin
                    $display("Frame on uart_tx_o at %0t ns with no byte written", $time);
                    note_error();
                    wait (uart_tx);
                end else begin
                    exp_bits = ref_frame(frame_q.pop_front(), cur_ctrl);
                    nbits    = frame_bits(cur_ctrl);
                    div      = cur_div;
                    repeat ((div + 1) / 2 - 1) @(negedge clk);
                    for (int i = 0; i < nbits; i++) begin
                        if (i > 0) repeat (div + 1) @(negedge clk);
                        check_line_bit(i, uart_tx, exp_bits[i]);
                    end
                end
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~
    // Test sequence
    initial begin
        logic [31:0] rdata;
        logic [7:0]  sent[$];
        logic [7:0]  b;
        rx_word_t    exp_word;
        uart_ctrl_t  ctrl;
        $timeformat(-9, 0, "", 0);
        bus_req   = 1'b0;
        bus       = '0;
        drv_line  = 1'b1;
        loop_sel  = 1'b1;
        mon_en    = 1'b0;
        cur_ctrl  = '0;
        cur_div   = `UART_DIV_RESET;
        lcg_state = 32'h4b95;
        n_checks  = 0;
        n_errors  = 0;
        test_errs = 0;
        wait (rst === 1'b0);
        @(posedge clk);

        read_reg(REG_CTRL, rdata);
        check_rdata("CTRL", rdata, 32'd0);
        read_reg(REG_DIV, rdata);
        check_rdata("DIV", rdata, 32'(`UART_DIV_RESET));
        read_reg(REG_PARAM, rdata);
        check_rdata("PARAM", rdata, {8'd0, 8'd8, 16'd16});
        read_reg(REG_STATUS, rdata);
        check_status(rdata, ST_ALL_EMPTY);
        end_test("reset values");

        for (int i = 0; i < N_RANDOM; i++) begin
            lcg_state = lcg_next(lcg_state);
            b = lcg_state[23:16];
            sent.push_back(b);
            write_reg(REG_TXDATA, {24'd0, b});   // Blocks while tx FIFO full
        end
        while (sent.size() > 0) begin
            poll_rx(rdata);
            exp_word.parity_err = 1'b0;
            exp_word.data       = sent.pop_front();
            check_rx_word(rdata, exp_word);
        end
        end_test("loopback no parity");

        write_reg(REG_DIV, 32'(DIV_FAST));
        for (int odd = 0; odd < 2; odd++) begin
            ctrl            = '0;
            ctrl.parity_en  = 1'b1;
            ctrl.parity_odd = odd[0];
            write_reg(REG_CTRL, {28'd0, ctrl});
            mon_en = 1'b1;
            for (int i = 0; i < N_PARITY; i++) begin
                lcg_state = lcg_next(lcg_state);
                b = lcg_state[23:16];
                sent.push_back(b);
                frame_q.push_back(b);
                write_reg(REG_TXDATA, {24'd0, b});
            end
            while (sent.size() > 0) begin
                poll_rx(rdata);
                exp_word.parity_err = 1'b0;
                exp_word.data       = sent.pop_front();
                check_rx_word(rdata, exp_word);
            end
        end
        mon_en = 1'b0;
        if (frame_q.size() != 0) begin
            $display("%0d frames never appeared on uart_tx_o", frame_q.size());
            note_error();
        end
        end_test("loopback with parity");

        @(posedge clk);
        loop_sel <= 1'b0;
        for (int i = 0; i < N_BAD; i++) begin
            lcg_state = lcg_next(lcg_state);
            b = lcg_state[23:16];
            drive_frame(b, i != 1);   // Middle frame keeps good parity
            poll_rx(rdata);
            exp_word.parity_err = (i != 1);
            exp_word.data       = b;
            check_rx_word(rdata, exp_word);
        end
        read_reg(REG_RXDATA, rdata);
        check_rdata("RXDATA empty", rdata, 32'd0);
        @(posedge clk);
        loop_sel <= 1'b1;
        end_test("parity errors");

        write_reg(REG_DIV, 32'hffff);
        write_reg(REG_CTRL, 32'd0);
        // First byte goes straight to the serializer
        for (int i = 0; i <= `UART_FIFO_DEPTH; i++) begin
            lcg_state = lcg_next(lcg_state);
            write_reg(REG_TXDATA, {24'd0, lcg_state[23:16]});
        end
        read_reg(REG_STATUS, rdata);
        check_status(rdata, ST_TX_FULL);
        ctrl          = '0;
        ctrl.tx_reset = 1'b1;
        write_reg(REG_CTRL, {28'd0, ctrl});
        write_reg(REG_CTRL, 32'd0);
        read_reg(REG_STATUS, rdata);
        check_status(rdata, ST_ALL_EMPTY);
        write_reg(REG_DIV, 32'(DIV_FAST));
        repeat (N_QUIET * 11 * (DIV_FAST + 1)) @(posedge clk);   // Room for a stray frame
        read_reg(REG_RXDATA, rdata);
        check_rdata("RXDATA after tx reset", rdata, 32'd0);
        end_test("flow control and reset");

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/uart_pkg.sv
src/uart_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_reg_file.sv
src/uart_top.sv
dv/tb_clk_gen.sv
dv/uart_checker.sv
dv/uart_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= uart_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
